/* design/dc_ctrl_params.svh */
`ifndef DC_CTRL_PARAMS_SVH
`define DC_CTRL_PARAMS_SVH

//////////////////////////////////////////////////
// console reset timing
//////////////////////////////////////////////////

// cycles a reset line stays pulled after the first hold cycle
`define DC_RESET_HOLD_CYCLES 32'd40

// glow period is 2**DC_GLOW_BIT cycles, needs at least 4
`define DC_GLOW_BIT 6

//////////////////////////////////////////////////
// host register port
//////////////////////////////////////////////////

`define DC_WB_ADDR_W 4
`define DC_WB_DATA_W 32

// word addresses
`define DC_REG_CONTROL    4'd0
`define DC_REG_STATUS     4'd1
`define DC_REG_PLL54_LOSS 4'd2
`define DC_REG_HDMI_LOSS  4'd3

`endif

/* design/dc_ctrl_pkg.sv */
`include "dc_ctrl_params.svh"

package dc_ctrl_pkg;

    //////////////////////////////////////////////////
    // bus and counter vectors
    //////////////////////////////////////////////////

    typedef logic [`DC_WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [`DC_WB_DATA_W-1:0] wb_data_t;

    // lock-loss event counter, wraps
    typedef logic [31:0] event_count_t;

    //////////////////////////////////////////////////
    // state encodings
    //////////////////////////////////////////////////

    // code 3 is treated like LED_MIRROR_OPT
    typedef enum logic [1:0] {
        LED_STATUS     = 2'd0,
        LED_MIRROR_DC  = 2'd1,
        LED_MIRROR_OPT = 2'd2
    } led_mode_t;

    typedef enum logic {
        RST_IDLE = 1'b0,
        RST_HOLD = 1'b1
    } hold_state_t;

endpackage

/* design/wb_ctrl_regs.sv */
`timescale 1ns/1ps
`include "dc_ctrl_params.svh"

module wb_ctrl_regs (
    input  logic                     control_clock,
    input  logic                     reset_dc,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  dc_ctrl_pkg::wb_addr_t    wb_adr,
    input  dc_ctrl_pkg::wb_data_t    wb_dat_w,
    input  logic                     pll54_lock_sync,
    input  logic                     hdmi_lock_sync,
    input  logic                     dc_nreset_pull,
    input  logic                     opt_nreset_pull,
    input  dc_ctrl_pkg::event_count_t pll54_loss_count,
    input  dc_ctrl_pkg::event_count_t hdmi_loss_count,
    output logic                     wb_ack,
    output dc_ctrl_pkg::wb_data_t    wb_dat_r,
    output logic                     dc_reset_req,
    output logic                     opt_reset_req,
    output logic                     pll54_loss_clr,
    output logic                     hdmi_loss_clr,
    output logic                     link_ready,
    output dc_ctrl_pkg::led_mode_t   led_mode
);

    import dc_ctrl_pkg::*;

    logic     access;
    logic     wr_strobe;
    wb_data_t control_rd;
    wb_data_t status_rd;

    // classic cycle, one ack per strobe, no wait states
    assign access    = wb_cyc && wb_stb && !wb_ack;
    assign wr_strobe = access && wb_we;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    //////////////////////////////////////////////////
    // control fields and request pulses
    //////////////////////////////////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            dc_reset_req   <= 1'b0;
            opt_reset_req  <= 1'b0;
            pll54_loss_clr <= 1'b0;
            hdmi_loss_clr  <= 1'b0;
            led_mode       <= LED_STATUS;
            link_ready     <= 1'b0;
        end else begin
            // pulses last only for the ack cycle
            dc_reset_req   <= 1'b0;
            opt_reset_req  <= 1'b0;
            pll54_loss_clr <= 1'b0;
            hdmi_loss_clr  <= 1'b0;
            if (wr_strobe) begin
                case (wb_adr)
                    `DC_REG_CONTROL: begin
                        dc_reset_req  <= wb_dat_w[0];
                        opt_reset_req <= wb_dat_w[1];
                        led_mode      <= led_mode_t'(wb_dat_w[3:2]);
                        link_ready    <= wb_dat_w[4];
                    end
                    `DC_REG_PLL54_LOSS: begin
                        pll54_loss_clr <= 1'b1;
                    end
                    `DC_REG_HDMI_LOSS: begin
                        hdmi_loss_clr <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // read path
    //////////////////////////////////////////////////

    // request bits are write-only, they read back as zero
    assign control_rd = {{(`DC_WB_DATA_W-5){1'b0}}, link_ready, led_mode, 2'b00};

    assign status_rd = {{(`DC_WB_DATA_W-4){1'b0}},
                        opt_nreset_pull, dc_nreset_pull,
                        hdmi_lock_sync, pll54_lock_sync};

    // data lines up with ack
    always_ff @(posedge control_clock) begin
        if (access) begin
            case (wb_adr)
                `DC_REG_CONTROL:    wb_dat_r <= control_rd;
                `DC_REG_STATUS:     wb_dat_r <= status_rd;
                `DC_REG_PLL54_LOSS: wb_dat_r <= pll54_loss_count;
                `DC_REG_HDMI_LOSS:  wb_dat_r <= hdmi_loss_count;
                default:            wb_dat_r <= '0;
            endcase
        end
    end

endmodule

/* design/pll_lock_monitor.sv */
`timescale 1ns/1ps

module pll_lock_monitor (
    input  logic                      control_clock,
    input  logic                      reset_dc,
    input  logic                      pll54_locked,
    input  logic                      pll_hdmi_locked,
    input  logic                      pll54_loss_clr,
    input  logic                      hdmi_loss_clr,
    output logic                      pll54_lock_sync,
    output logic                      hdmi_lock_sync,
    output dc_ctrl_pkg::event_count_t pll54_loss_count,
    output dc_ctrl_pkg::event_count_t hdmi_loss_count
);

    import dc_ctrl_pkg::*;

    // channel 0 is pll54, channel 1 is the hdmi pll
    logic [1:0]   lock_in;
    logic [1:0]   loss_clr;
    logic [1:0]   lock_meta;
    logic [1:0]   lock_sync;
    logic [1:0]   lock_prev;
    logic [1:0]   lock_loss;
    event_count_t loss_count [2];

    assign lock_in  = {pll_hdmi_locked, pll54_locked};
    assign loss_clr = {hdmi_loss_clr, pll54_loss_clr};

    //////////////////////////////////////////////////
    // two-flop synchronizers plus edge history
    //////////////////////////////////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            lock_meta <= 2'b00;
            lock_sync <= 2'b00;
            lock_prev <= 2'b00;
        end else begin
            lock_meta <= lock_in;
            lock_sync <= lock_meta;
            lock_prev <= lock_sync;
        end
    end

    // falling edge of the synced lock only
    assign lock_loss = lock_prev & ~lock_sync;

    //////////////////////////////////////////////////
    // loss counters
    //////////////////////////////////////////////////

    always_ff @(posedge control_clock) begin
        for (int i = 0; i < 2; i++) begin
            if (reset_dc) begin
                loss_count[i] <= '0;
            end else if (loss_clr[i]) begin
                // host clear beats a loss on the same edge
                loss_count[i] <= '0;
            end else if (lock_loss[i]) begin
                loss_count[i] <= loss_count[i] + 1'b1;
            end
        end
    end

    assign pll54_lock_sync  = lock_sync[0];
    assign hdmi_lock_sync   = lock_sync[1];
    assign pll54_loss_count = loss_count[0];
    assign hdmi_loss_count  = loss_count[1];

endmodule

/* design/console_reset_gen.sv */
`timescale 1ns/1ps
`include "dc_ctrl_params.svh"

module console_reset_gen (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic reset_req,
    output logic nreset_pull
);

    import dc_ctrl_pkg::*;

    hold_state_t state;
    logic [31:0] hold_count;

    //////////////////////////////////////////////////
    // hold FSM
    //////////////////////////////////////////////////

    // line is pulled for hold count + 1 cycles
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            state      <= RST_IDLE;
            hold_count <= '0;
        end else if (reset_req) begin
            // a new request restarts the hold
            state      <= RST_HOLD;
            hold_count <= '0;
        end else begin
            case (state)
                RST_IDLE: begin
                    hold_count <= '0;
                end
                RST_HOLD: begin
                    if (hold_count == `DC_RESET_HOLD_CYCLES) begin
                        state <= RST_IDLE;
                    end else begin
                        hold_count <= hold_count + 1'b1;
                    end
                end
                default: begin
                    state <= RST_IDLE;
                end
            endcase
        end
    end

    // 1 enables the open-drain driver, pin goes low
    assign nreset_pull = (state == RST_HOLD);

endmodule

/* design/status_led_ctrl.sv */
`timescale 1ns/1ps
`include "dc_ctrl_params.svh"

module status_led_ctrl (
    input  logic                   control_clock,
    input  logic                   reset_dc,
    input  dc_ctrl_pkg::led_mode_t led_mode,
    input  logic                   hdmi_lock_sync,
    input  logic                   link_ready,
    input  logic                   dc_nreset_pull,
    input  logic                   opt_nreset_pull,
    output logic                   status_led_out,
    output logic                   status_led_oe
);

    import dc_ctrl_pkg::*;

    localparam int GLOW_W  = `DC_GLOW_BIT;
    localparam int LEVEL_W = 3;

    logic [GLOW_W-1:0]  glow_cnt;
    logic [LEVEL_W-1:0] glow_level;
    logic [LEVEL_W:0]   pwm_acc;
    logic               glow;

    //////////////////////////////////////////////////
    // slow glow
    //////////////////////////////////////////////////

    // top bit picks ramp direction, next bits set the duty
    assign glow_level = glow_cnt[GLOW_W-2 -: LEVEL_W] ^ {LEVEL_W{glow_cnt[GLOW_W-1]}};

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            glow_cnt <= '0;
            pwm_acc  <= '0;
        end else begin
            glow_cnt <= glow_cnt + 1'b1;
            // first-order delta-sigma, carry out is the PWM bit
            pwm_acc  <= {1'b0, pwm_acc[LEVEL_W-1:0]} + {1'b0, glow_level};
        end
    end

    assign glow = pwm_acc[LEVEL_W];

    //////////////////////////////////////////////////
    // LED mode select
    //////////////////////////////////////////////////

    // LED is active low, reset leaves it dark
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            status_led_out <= 1'b1;
            status_led_oe  <= 1'b1;
        end else begin
            case (led_mode)
                LED_STATUS: begin
                    status_led_oe <= 1'b1;
                    if (!hdmi_lock_sync) begin
                        status_led_out <= 1'b1;
                    end else if (link_ready) begin
                        status_led_out <= 1'b0;
                    end else begin
                        // locked, link not up yet
                        status_led_out <= ~glow;
                    end
                end
                LED_MIRROR_DC: begin
                    status_led_out <= 1'b0;
                    status_led_oe  <= dc_nreset_pull;
                end
                default: begin
                    // mirror opt, also for code 3
                    status_led_out <= 1'b0;
                    status_led_oe  <= opt_nreset_pull;
                end
            endcase
        end
    end

endmodule

/* design/dc_ctrl_top.sv */
`timescale 1ns/1ps

module dc_ctrl_top (
    input  logic                  control_clock,
    input  logic                  reset_dc,
    input  logic                  pll54_locked,
    input  logic                  pll_hdmi_locked,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  dc_ctrl_pkg::wb_addr_t wb_adr,
    input  dc_ctrl_pkg::wb_data_t wb_dat_w,
    output logic                  wb_ack,
    output dc_ctrl_pkg::wb_data_t wb_dat_r,
    output logic                  dc_nreset_pull,
    output logic                  opt_nreset_pull,
    output logic                  status_led_out,
    output logic                  status_led_oe
);

    import dc_ctrl_pkg::*;

    logic         dc_reset_req;
    logic         opt_reset_req;
    logic         pll54_loss_clr;
    logic         hdmi_loss_clr;
    logic         link_ready;
    led_mode_t    led_mode;
    logic         pll54_lock_sync;
    logic         hdmi_lock_sync;
    event_count_t pll54_loss_count;
    event_count_t hdmi_loss_count;

    //////////////////////////////////////////////////
    // host side and lock inputs
    //////////////////////////////////////////////////

    wb_ctrl_regs u_regs (
        .control_clock    (control_clock),
        .reset_dc         (reset_dc),
        .wb_cyc           (wb_cyc),
        .wb_stb           (wb_stb),
        .wb_we            (wb_we),
        .wb_adr           (wb_adr),
        .wb_dat_w         (wb_dat_w),
        .pll54_lock_sync  (pll54_lock_sync),
        .hdmi_lock_sync   (hdmi_lock_sync),
        .dc_nreset_pull   (dc_nreset_pull),
        .opt_nreset_pull  (opt_nreset_pull),
        .pll54_loss_count (pll54_loss_count),
        .hdmi_loss_count  (hdmi_loss_count),
        .wb_ack           (wb_ack),
        .wb_dat_r         (wb_dat_r),
        .dc_reset_req     (dc_reset_req),
        .opt_reset_req    (opt_reset_req),
        .pll54_loss_clr   (pll54_loss_clr),
        .hdmi_loss_clr    (hdmi_loss_clr),
        .link_ready       (link_ready),
        .led_mode         (led_mode)
    );

    pll_lock_monitor u_lock_mon (
        .control_clock    (control_clock),
        .reset_dc         (reset_dc),
        .pll54_locked     (pll54_locked),
        .pll_hdmi_locked  (pll_hdmi_locked),
        .pll54_loss_clr   (pll54_loss_clr),
        .hdmi_loss_clr    (hdmi_loss_clr),
        .pll54_lock_sync  (pll54_lock_sync),
        .hdmi_lock_sync   (hdmi_lock_sync),
        .pll54_loss_count (pll54_loss_count),
        .hdmi_loss_count  (hdmi_loss_count)
    );

    //////////////////////////////////////////////////
    // console reset lines
    //////////////////////////////////////////////////

    console_reset_gen dc_reset_gen (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .reset_req     (dc_reset_req),
        .nreset_pull   (dc_nreset_pull)
    );

    console_reset_gen opt_reset_gen (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .reset_req     (opt_reset_req),
        .nreset_pull   (opt_nreset_pull)
    );

    //////////////////////////////////////////////////
    // status LED
    //////////////////////////////////////////////////

    status_led_ctrl u_led (
        .control_clock   (control_clock),
        .reset_dc        (reset_dc),
        .led_mode        (led_mode),
        .hdmi_lock_sync  (hdmi_lock_sync),
        .link_ready      (link_ready),
        .dc_nreset_pull  (dc_nreset_pull),
        .opt_nreset_pull (opt_nreset_pull),
        .status_led_out  (status_led_out),
        .status_led_oe   (status_led_oe)
    );

endmodule

/* dv/dc_ctrl_tb.sv */
`timescale 1ns/1ps
`include "dc_ctrl_params.svh"

module dc_ctrl_tb;

    import dc_ctrl_pkg::*;

    localparam int NUM_TESTS = 5;
    localparam int HOLD      = `DC_RESET_HOLD_CYCLES;
    localparam int GLOW_SPAN = 4 * (1 << `DC_GLOW_BIT);

    logic     control_clock;
    logic     reset_dc;
    logic     pll54_locked;
    logic     pll_hdmi_locked;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    logic     wb_ack;
    wb_data_t wb_dat_r;
    logic     dc_nreset_pull;
    logic     opt_nreset_pull;
    logic     status_led_out;
    logic     status_led_oe;
    string    test_name;

    dc_ctrl_top DUT (.*);

    initial begin
        control_clock = 1'b0;
        forever #4 control_clock = ~control_clock;
    end

    // run limit from the test count and the hold time
    initial begin
        repeat (NUM_TESTS * (4 * HOLD + 2000)) @(posedge control_clock);
        $display("Simulation failed");
        $fatal(1, "watchdog expired before the tests finished");
    end

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_data(input string what, input wb_data_t exp, input wb_data_t act);
        if (act !== exp) begin
            $display("** Error: %s %s expected 0x%08h actual 0x%08h", test_name, what, exp, act);
            $display("Simulation failed");
            $fatal(1, "register data mismatch");
        end
    endtask

    task automatic check_count(input string what, input event_count_t exp,
                               input event_count_t act);
        if (act !== exp) begin
            $display("** Error: %s %s expected %0d actual %0d", test_name, what, exp, act);
            $display("Simulation failed");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error: %s %s expected %b actual %b", test_name, what, exp, act);
            $display("Simulation failed");
            $fatal(1, "signal level mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // bus and stimulus helpers
    //////////////////////////////////////////////////

    // ack seen at a falling edge, bus released on the next rising edge
    task automatic wait_ack(output wb_data_t data);
        int waited;
        waited = 0;
        @(negedge control_clock);
        while (!wb_ack && waited < 4) begin
            waited++;
            @(negedge control_clock);
        end
        if (!wb_ack) begin
            $display("Simulation failed");
            $fatal(1, "no Wishbone ack within 4 cycles");
        end else begin
            data = wb_dat_r;
            @(posedge control_clock);
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t data);
        wb_data_t ignored;
        @(posedge control_clock);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        wait_ack(ignored);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t data);
        @(posedge control_clock);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        wait_ack(data);
    endtask

    // one lock level held for 6 cycles
    task automatic set_lock(input bit hdmi, input logic level);
        @(posedge control_clock);
        if (hdmi) begin
            pll_hdmi_locked <= level;
        end else begin
            pll54_locked <= level;
        end
        repeat (5) @(posedge control_clock);
    endtask

    function automatic logic line_pull(input bit opt);
        return opt ? opt_nreset_pull : dc_nreset_pull;
    endfunction

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic reset_state_and_regs();
        wb_data_t rd;
        wb_data_t wr;
        wb_addr_t adr;
        test_name = "reset_state_and_regs";
        @(negedge control_clock);
        check_bit("ack after reset", 1'b0, wb_ack);
        check_bit("dc pull after reset", 1'b0, dc_nreset_pull);
        check_bit("opt pull after reset", 1'b0, opt_nreset_pull);
        check_bit("led enable after reset", 1'b1, status_led_oe);
        check_bit("led value after reset", 1'b1, status_led_out);
        wb_read(`DC_REG_CONTROL, rd);
        check_data("control after reset", '0, rd);
        repeat (4) begin
            wr = $urandom;
            // keep the request bits clear
            wr[1:0] = 2'b00;
            wb_write(`DC_REG_CONTROL, wr);
            wb_read(`DC_REG_CONTROL, rd);
            check_data("control readback", wr & 32'h1c, rd);
        end
        adr = wb_addr_t'(4 + ($urandom % 12));
        wb_write(adr, $urandom);
        wb_read(adr, rd);
        check_data("unmapped read", '0, rd);
        wb_read(`DC_REG_CONTROL, rd);
        check_data("control after unmapped write", wr & 32'h1c, rd);
        wb_write(`DC_REG_CONTROL, '0);
    endtask

    task automatic reset_hold(input bit opt);
        wb_data_t rd;
        int       cycles;
        test_name = opt ? "reset_hold_opt" : "reset_hold_dc";
        fork
            begin
                wb_write(`DC_REG_CONTROL, opt ? 32'h2 : 32'h1);
                wb_read(`DC_REG_STATUS, rd);
                check_bit("status pull bit", 1'b1, opt ? rd[3] : rd[2]);
                check_bit("status other pull bit", 1'b0, opt ? rd[2] : rd[3]);
            end
            begin
                @(negedge control_clock);
                while (!wb_ack) @(negedge control_clock);
                check_bit("pull on ack edge", 1'b0, line_pull(opt));
                cycles = 0;
                @(negedge control_clock);
                while (line_pull(opt) && cycles <= HOLD + 4) begin
                    check_bit("other line during hold", 1'b0, line_pull(!opt));
                    cycles++;
                    @(negedge control_clock);
                end
                check_count("hold cycles", event_count_t'(HOLD + 1), event_count_t'(cycles));
            end
        join
    endtask

    task automatic lock_loss_counting();
        wb_data_t rd;
        wb_addr_t own;
        wb_addr_t other;
        int       falls;
        test_name = "lock_loss_counting";
        set_lock(1'b0, 1'b1);
        set_lock(1'b1, 1'b1);
        wb_write(`DC_REG_PLL54_LOSS, '0);
        wb_write(`DC_REG_HDMI_LOSS, '0);
        for (int ch = 0; ch < 2; ch++) begin
            own   = (ch == 1) ? `DC_REG_HDMI_LOSS : `DC_REG_PLL54_LOSS;
            other = (ch == 1) ? `DC_REG_PLL54_LOSS : `DC_REG_HDMI_LOSS;
            falls = 1 + ($urandom % 8);
            repeat (falls) begin
                set_lock(ch[0], 1'b0);
                set_lock(ch[0], 1'b1);
            end
            repeat (5) @(posedge control_clock);
            wb_read(own, rd);
            check_count("loss counter", event_count_t'(falls), rd);
            wb_read(other, rd);
            check_count("untouched counter", '0, rd);
            wb_write(own, $urandom);
            wb_read(own, rd);
            check_count("cleared counter", '0, rd);
        end
        wb_read(`DC_REG_STATUS, rd);
        check_data("status both locked", 32'h3, rd);
        set_lock(1'b0, 1'b0);
        wb_read(`DC_REG_STATUS, rd);
        check_data("status pll54 unlocked", 32'h2, rd);
        set_lock(1'b0, 1'b1);
    endtask

    task automatic led_status_mode();
        bit seen_on;
        bit seen_off;
        test_name = "led_status_mode";
        // link ready set, a missing lock still wins
        wb_write(`DC_REG_CONTROL, 32'h10);
        set_lock(1'b1, 1'b0);
        repeat (200) begin
            @(negedge control_clock);
            check_bit("led value without lock", 1'b1, status_led_out);
            check_bit("led enable", 1'b1, status_led_oe);
        end
        set_lock(1'b1, 1'b1);
        wb_write(`DC_REG_CONTROL, 32'h10);
        repeat (3) @(posedge control_clock);
        repeat (200) begin
            @(negedge control_clock);
            check_bit("led value with link ready", 1'b0, status_led_out);
        end
        // locked but no link, expect the glow
        wb_write(`DC_REG_CONTROL, '0);
        repeat (3) @(posedge control_clock);
        seen_on  = 1'b0;
        seen_off = 1'b0;
        repeat (GLOW_SPAN) begin
            @(negedge control_clock);
            if (status_led_out) begin
                seen_off = 1'b1;
            end else begin
                seen_on = 1'b1;
            end
        end
        check_bit("glow reaches led on", 1'b1, seen_on);
        check_bit("glow reaches led off", 1'b1, seen_off);
    endtask

    task automatic led_mirror_modes(input bit opt);
        wb_data_t mode_bits;
        logic     prev_pull;
        bit       seen_pull;
        test_name = opt ? "led_mirror_opt" : "led_mirror_dc";
        // mode field sits in bits 3:2
        mode_bits = (opt ? wb_data_t'(LED_MIRROR_OPT) : wb_data_t'(LED_MIRROR_DC)) << 2;
        wb_write(`DC_REG_CONTROL, mode_bits);
        repeat (3) @(posedge control_clock);
        seen_pull = 1'b0;
        fork
            wb_write(`DC_REG_CONTROL, mode_bits | (opt ? 32'h2 : 32'h1));
            begin
                @(negedge control_clock);
                while (!wb_ack) @(negedge control_clock);
                prev_pull = line_pull(opt);
                repeat (HOLD + 12) begin
                    @(negedge control_clock);
                    // led register lags the line by one cycle
                    check_bit("led enable follows line", prev_pull, status_led_oe);
                    check_bit("led value in mirror mode", 1'b0, status_led_out);
                    prev_pull = line_pull(opt);
                    seen_pull = seen_pull | prev_pull;
                end
            end
        join
        check_bit("line was pulled", 1'b1, seen_pull);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        reset_dc        <= 1'b1;
        pll54_locked    <= 1'b0;
        pll_hdmi_locked <= 1'b0;
        wb_cyc          <= 1'b0;
        wb_stb          <= 1'b0;
        wb_we           <= 1'b0;
        wb_adr          <= '0;
        wb_dat_w        <= '0;
        void'($urandom(32'h10f2_89bb));
        repeat (2) @(posedge control_clock);
        reset_dc <= 1'b0;
        @(posedge control_clock);
        reset_state_and_regs();
        reset_hold(1'b0);
        reset_hold(1'b1);
        lock_loss_counting();
        led_status_mode();
        led_mirror_modes(1'b0);
        led_mirror_modes(1'b1);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* flist.f */
+incdir+design
design/dc_ctrl_pkg.sv
design/wb_ctrl_regs.sv
design/pll_lock_monitor.sv
design/console_reset_gen.sv
design/status_led_ctrl.sv
design/dc_ctrl_top.sv
dv/dc_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module dc_ctrl_tb -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/Vdc_ctrl_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation ended with status $sim_status"
    exit $sim_status
fi

exit 0
